// ==== files.f ====
+incdir+include
hdl/ucstats_pkg.sv
hdl/ucstats_ifs.sv
hdl/uc_debounce.sv
hdl/uc_sync_front.sv
hdl/uc_xfer_fsm.sv
hdl/stat_bank_ram.sv
hdl/bank_sel_ctrl.sv
hdl/ucstats_top.sv
sim/tb_ucstats.sv

// ==== Bender.yml ====
package:
  name: ucstats

sources:
  - files:
      - hdl/ucstats_pkg.sv
      - hdl/ucstats_ifs.sv
      - hdl/uc_debounce.sv
      - hdl/uc_sync_front.sv
      - hdl/uc_xfer_fsm.sv
      - hdl/stat_bank_ram.sv
      - hdl/bank_sel_ctrl.sv
      - hdl/ucstats_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_ucstats.sv

// ==== include/uc_bus_tasks.svh ====
/* uC bus master and link engine tasks */
`ifndef UC_BUS_TASKS_SVH
`define UC_BUS_TASKS_SVH

// each uC level is held long enough for sync and debounce
localparam int hold_clk = 8;

// --------------------------------------------------
// uC bus master
// --------------------------------------------------
task automatic wait_clk(input int n);
   repeat (n) @(negedge clk);
endtask

// data settles before the valid rise that samples it
task automatic send_byte(input logic [7:0] b);
   uc_data_in = b;
   wait_clk(hold_clk / 2);
   uc_valid = 1'b1;
   wait_clk(hold_clk);
   uc_valid = 1'b0;
   wait_clk(hold_clk);
endtask

// select the DUT and send the address low byte first
task automatic start_xfer(input logic [15:0] addr);
   uc_master = 1'b1;
   uc_cs     = 1'b1;
   wait_clk(hold_clk);
   send_byte(addr[7:0]);
   send_byte(addr[15:8]);
endtask

task automatic end_xfer();
   uc_cs = 1'b0;
   // leave room for the FSM to get back to idle
   wait_clk(hold_clk + 4);
endtask

// write every word of wr_words_q as one burst
task automatic uc_write_burst(input logic [15:0] addr);
   start_xfer(addr);
   foreach (wr_words_q[i]) begin
      for (int k = 0; k < 4; k++) begin
         send_byte(wr_words_q[i][8*k +: 8]);
      end
   end
   end_xfer();
endtask

// cs drops after n_bytes data bytes of a write
task automatic uc_abort_write(input logic [15:0] addr, input logic [31:0] word,
                              input int n_bytes);
   start_xfer(addr);
   for (int k = 0; k < n_bytes; k++) begin
      send_byte(word[8*k +: 8]);
   end
   end_xfer();
endtask

// val_ok stays high only if every byte came with uc_data_out_val
task automatic uc_read_word(input logic [15:0] addr, output logic [31:0] word,
                            output logic val_ok);
   start_xfer(addr);
   // hand over the bus after the last address falling edge
   uc_master = 1'b0;
   wait_clk(hold_clk);
   val_ok = 1'b1;
   for (int k = 0; k < 4; k++) begin
      uc_valid = 1'b1;
      wait_clk(hold_clk);
      // byte is held until the next valid fall
      word[8*k +: 8] = uc_data_out;
      val_ok = val_ok & uc_data_out_val;
      uc_valid = 1'b0;
      wait_clk(hold_clk);
   end
   end_xfer();
endtask

// --------------------------------------------------
// link engine
// --------------------------------------------------
// request is held until the grant one cycle later
task automatic le_open();
   int n;
   n = 0;
   check("le_gnt", le_gnt, 0);
   le_req = 1'b1;
   @(negedge clk);
   n++;
   while (!le_gnt) begin
      @(negedge clk);
      n++;
   end
   check("le_gnt latency", n, 1);
   le_req = 1'b0;
endtask

// back to back addresses with data checked two cycles after each one
task automatic le_read_burst();
   int n;
   n = le_addr_q.size();
   for (int i = 0; i < n + 2; i++) begin
      @(negedge clk);
      if (i >= 2) begin
         check("le_data", le_data, le_exp_q[i-2]);
      end
      if (i < n) begin
         le_addr = 10'(le_addr_q[i]);
      end
   end
endtask

// one cycle done pulse ends the read
task automatic le_close();
   le_done = 1'b1;
   @(negedge clk);
   le_done = 1'b0;
endtask

`endif

// ==== sim/tb_ucstats.sv ====
/* uC stats bridge testbench */
`timescale 1ns/1ns

module tb_ucstats import ucstats_pkg::*; ();

   localparam int n_bursts  = 6;
   localparam int max_words = 4;
   // writes, readbacks, register and link engine accesses
   localparam int n_xfers        = n_bursts * (1 + max_words) + 16;
   localparam int timeout_cycles = 400 * n_xfers;

   logic        clk;
   logic        uc_rst_n;
   logic        uc_cs;
   logic [7:0]  uc_data_in;
   logic        uc_valid;
   logic        uc_master;
   logic [7:0]  uc_data_out;
   logic        uc_data_out_val;
   logic        le_req;
   logic [9:0]  le_addr;
   logic        le_done;
   logic [31:0] le_data;
   logic        le_gnt;

   // --------------------------------------------------
   // reference model state
   // --------------------------------------------------
   logic [31:0] model_mem [2][1024];
   // bank the uC owns while the link engine reads the other
   bit          uc_bank;
   bit          le_busy;
   bit          swap_pending;
   integer      seed;
   int          errors;
   int          checks;
   int          cycles;
   logic [31:0] wr_words_q [$];
   int          le_addr_q [$];
   logic [31:0] le_exp_q [$];
   int          written_q [$];
   int          new_q [$];

   ucstats_top uut (
      .clk             (clk),
      .uc_rst_n        (uc_rst_n),
      .uc_cs           (uc_cs),
      .uc_data_in      (uc_data_in),
      .uc_valid        (uc_valid),
      .uc_master       (uc_master),
      .uc_data_out     (uc_data_out),
      .uc_data_out_val (uc_data_out_val),
      .le_req          (le_req),
      .le_addr         (le_addr),
      .le_done         (le_done),
      .le_data         (le_data),
      .le_gnt          (le_gnt)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   `include "uc_bus_tasks.svh"

   // --------------------------------------------------
   // model side helpers
   // --------------------------------------------------
   task automatic model_burst(input int base);
      foreach (wr_words_q[i]) begin
         model_mem[uc_bank][base + i] = wr_words_q[i];
      end
   endtask

   task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
      logic [31:0] word;
      logic        ok;
      uc_read_word(addr, word, ok);
      check("uc read word", word, exp);
      check("uc_data_out_val", ok, 1);
   endtask

   // swap waits for the end of an open link engine read
   task automatic interval_write();
      wr_words_q.delete();
      wr_words_q.push_back($random(seed));
      uc_write_burst(16'h8401);
      if (le_busy) begin
         swap_pending = 1'b1;
      end else begin
         uc_bank = ~uc_bank;
      end
      wait_clk(4);
   endtask

   task automatic le_expect_burst();
      le_exp_q.delete();
      foreach (le_addr_q[i]) begin
         le_exp_q.push_back(model_mem[!uc_bank][le_addr_q[i]]);
      end
      le_read_burst();
   endtask

   task automatic le_end();
      le_close();
      le_busy = 1'b0;
      if (swap_pending) begin
         uc_bank      = ~uc_bank;
         swap_pending = 1'b0;
      end
      wait_clk(6);
   endtask

   // --------------------------------------------------
   // run limit
   // --------------------------------------------------
   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
         $display("Checks failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      int len;
      int base;
      seed         = 30;
      errors       = 0;
      checks       = 0;
      cycles       = 0;
      uc_bank      = 1'b0;
      le_busy      = 1'b0;
      swap_pending = 1'b0;
      uc_rst_n     = 1'b0;
      uc_cs        = 1'b0;
      uc_data_in   = '0;
      uc_valid     = 1'b0;
      uc_master    = 1'b1;
      le_req       = 1'b0;
      le_addr      = '0;
      le_done      = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      uc_rst_n = 1'b1;

      // outputs quiet after reset
      check("uc_data_out_val", uc_data_out_val, 0);
      check("le_gnt", le_gnt, 0);
      check("le_data", le_data, 0);
      wait_clk(4);

      // random bursts into the uC bank with each word read back
      for (int b = 0; b < n_bursts; b++) begin
         len  = 1 + ($unsigned($random(seed)) % max_words);
         base = $unsigned($random(seed)) % (1025 - len);
         wr_words_q.delete();
         for (int k = 0; k < len; k++) begin
            wr_words_q.push_back($random(seed));
         end
         uc_write_burst(16'h8000 | 16'(base));
         model_burst(base);
         for (int k = 0; k < len; k++) begin
            read_check(16'(base + k), model_mem[uc_bank][base + k]);
            written_q.push_back(base + k);
         end
      end

      // fixed register, bad reads and an ignored write with bit 11 set
      read_check(16'h0402, 32'hC001C0DE);
      read_check(16'h2000 | 16'(written_q[0]), 32'hDEADBEEF);
      read_check(16'h0401, 32'hDEADBEEF);
      wr_words_q.delete();
      wr_words_q.push_back($random(seed));
      uc_write_burst(16'h8800 | 16'(written_q[0]));
      read_check(16'(written_q[0]), model_mem[uc_bank][written_q[0]]);

      // cs drops before the fourth data byte
      uc_abort_write(16'h8000 | 16'(written_q[1]), $random(seed),
                     $unsigned($random(seed)) % 4);
      read_check(16'(written_q[1]), model_mem[uc_bank][written_q[1]]);

      // swap with no read open so the link engine sees the written bank
      interval_write();
      le_open();
      le_busy   = 1'b1;
      le_addr_q = written_q;
      le_expect_burst();
      le_end();

      // fill the new uC bank and then request a swap during an open read
      base = $unsigned($random(seed)) % 1022;
      wr_words_q.delete();
      for (int k = 0; k < 3; k++) begin
         wr_words_q.push_back($random(seed));
         new_q.push_back(base + k);
      end
      uc_write_burst(16'h8000 | 16'(base));
      model_burst(base);
      le_open();
      le_busy = 1'b1;
      le_expect_burst();
      interval_write();
      // old bank still visible until le_done
      le_expect_burst();
      le_end();
      le_open();
      le_busy   = 1'b1;
      le_addr_q = new_q;
      le_expect_burst();
      le_end();
      // uC owns the first bank again
      read_check(16'(written_q[0]), model_mem[uc_bank][written_q[0]]);

      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== hdl/ucstats_top.sv ====
/* uC statistics bridge top */
`timescale 1ns/1ns

module ucstats_top import ucstats_pkg::*; (
   input  logic                   clk,
   input  logic                   uc_rst_n,
   // uC register transfer bus
   input  logic                   uc_cs,
   input  logic [uc_byte_w-1:0]   uc_data_in,
   input  logic                   uc_valid,
   input  logic                   uc_master,
   output logic [uc_byte_w-1:0]   uc_data_out,
   output logic                   uc_data_out_val,
   // link engine read port
   input  logic                   le_req,
   input  logic [stat_addr_w-1:0] le_addr,
   input  logic                   le_done,
   output logic [stat_data_w-1:0] le_data,
   output logic                   le_gnt
);

   uc_line_if  u_line ();
   stat_ram_if u_ram ();

   // uC bank select, from swap control to the RAM
   logic bank_sel;

   uc_sync_front u_front (
      .clk        (clk),
      .uc_rst_n   (uc_rst_n),
      .uc_cs      (uc_cs),
      .uc_valid   (uc_valid),
      .uc_master  (uc_master),
      .uc_data_in (uc_data_in),
      .bus        (u_line.front)
   );

   uc_xfer_fsm u_fsm (
      .clk             (clk),
      .uc_rst_n        (uc_rst_n),
      .bus             (u_line.fsm),
      .ram             (u_ram.fsm),
      .uc_data_out     (uc_data_out),
      .uc_data_out_val (uc_data_out_val)
   );

   stat_bank_ram u_stat_ram (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .ram      (u_ram.ram),
      .bank_sel (bank_sel),
      .le_addr  (le_addr),
      .le_data  (le_data)
   );

   bank_sel_ctrl u_bank_ctrl (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .mon      (u_ram.mon),
      .le_req   (le_req),
      .le_done  (le_done),
      .le_gnt   (le_gnt),
      .bank_sel (bank_sel)
   );

endmodule

// ==== hdl/bank_sel_ctrl.sv ====
/* stat bank swap control */
`timescale 1ns/1ns

module bank_sel_ctrl import ucstats_pkg::*; (
   input  logic    clk,
   input  logic    uc_rst_n,
   stat_ram_if.mon mon,
   input  logic    le_req,
   input  logic    le_done,
   output logic    le_gnt,
   output logic    bank_sel
);

   bank_state_t state;
   logic        le_reading_q;
   logic        le_reading;

   // --------------------------------------------------
   // link engine read tracking
   // --------------------------------------------------
   // open from req until the done pulse
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_reading_q <= 1'b0;
         le_gnt       <= 1'b0;
      end else begin
         le_reading_q <= le_req ? 1'b1 : le_done ? 1'b0 : le_reading_q;
         // grant is the request one cycle later
         le_gnt       <= le_req;
      end
   end

   // a pending request already locks the bank
   assign le_reading = le_reading_q | le_req;

   // --------------------------------------------------
   // swap state machine
   // --------------------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= bk_idle;
      end else begin
         case (state)
            bk_idle:          state <= mon.interval_done ? bk_interval_done :
                                       mon.wr_en ? bk_writing : bk_idle;
            bk_writing:       state <= mon.interval_done ? bk_interval_done : bk_writing;
            // hold while the link engine reads, a new write restarts the interval
            bk_interval_done: state <= le_reading ? bk_interval_done :
                                       mon.wr_en ? bk_writing : bk_update;
            bk_update:        state <= bk_idle;
            default:          state <= bk_error;
         endcase
      end
   end

   // 1 means uC owns bank 1
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         bank_sel <= 1'b0;
      end else if (state == bk_update) begin
         bank_sel <= ~bank_sel;
      end
   end

endmodule

// ==== hdl/stat_bank_ram.sv ====
/* double-buffered stat RAM */
`timescale 1ns/1ns

module stat_bank_ram import ucstats_pkg::*; (
   input  logic                   clk,
   input  logic                   uc_rst_n,
   stat_ram_if.ram                ram,
   input  logic                   bank_sel,
   input  logic [stat_addr_w-1:0] le_addr,
   output logic [stat_data_w-1:0] le_data
);

   // --------------------------------------------------
   // two banks, uC owns bank bank_sel, link engine the other
   // --------------------------------------------------
   for (genvar b = 0; b < 2; b++) begin : g_bank
      logic [stat_data_w-1:0] mem [stat_words];
      logic                   uc_owned;
      logic [stat_addr_w-1:0] rd_addr;
      logic [stat_data_w-1:0] rd_q;

      assign uc_owned = (bank_sel == 1'(b));
      assign rd_addr  = uc_owned ? ram.addr : le_addr;

      // writes only ever reach the uC bank
      always_ff @(posedge clk) begin
         if (ram.wr_en && uc_owned) begin
            mem[ram.addr] <= ram.wr_data;
         end
         rd_q <= mem[rd_addr];
      end
   end

   // uC read data, one cycle after the address
   assign ram.rd_data = bank_sel ? g_bank[1].rd_q : g_bank[0].rd_q;

   // extra register gives the link engine its two cycle latency
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_data <= '0;
      end else begin
         le_data <= bank_sel ? g_bank[0].rd_q : g_bank[1].rd_q;
      end
   end

endmodule

// ==== hdl/uc_xfer_fsm.sv ====
/* uC register transfer FSM */
`timescale 1ns/1ns

module uc_xfer_fsm import ucstats_pkg::*; (
   input  logic                 clk,
   input  logic                 uc_rst_n,
   uc_line_if.fsm               bus,
   stat_ram_if.fsm              ram,
   output logic [uc_byte_w-1:0] uc_data_out,
   output logic                 uc_data_out_val
);

   uc_state_t              state;
   logic [uc_addr_w-1:0]   uc_addr;
   logic [stat_data_w-1:0] uc_data;
   logic [stat_data_w-1:0] rd_word;
   // stat RAM data lands the cycle after st_rd_ram
   logic                   rd_pending;
   logic                   cs_lost;
   logic                   is_wr;
   logic                   is_stat;
   logic                   is_intv;
   logic                   is_cool;
   logic                   invalid_addr;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------
   assign cs_lost = ~bus.cs;
   assign is_wr   = uc_addr[uc_wr_bit];
   assign is_stat = (uc_addr[space_hi:space_lo] == space_stat);
   assign is_intv = (uc_addr[space_hi:space_lo] == space_fpga) &&
                    (uc_addr[stat_addr_w-1:0] == reg_interval_done);
   assign is_cool = (uc_addr[space_hi:space_lo] == space_fpga) &&
                    (uc_addr[stat_addr_w-1:0] == reg_coolcode);
   // reserved bits 14:12, bit 11, or an fpga offset not legal for the direction
   assign invalid_addr = (|uc_addr[uc_wr_bit-1:space_hi+1]) || uc_addr[space_hi] ||
                         (!is_stat && (is_wr ? !is_intv : !is_cool));

   // --------------------------------------------------
   // transfer state machine
   // --------------------------------------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:       state <= bus.cs ? st_addr0 : st_idle;
            st_addr0:      state <= cs_lost ? st_early_done :
                                    bus.valid_rise ? st_addr1 : st_addr0;
            st_addr1:      state <= cs_lost ? st_early_done :
                                    bus.valid_rise ? st_addr_dec : st_addr1;
            // bad write waits out CS and bad read returns the filler word
            st_addr_dec:   state <= cs_lost ? st_early_done :
                                    (invalid_addr && is_wr) ? st_invalid_wr :
                                    is_wr ? st_data0 :
                                    (invalid_addr || !is_stat) ? st_rd_master : st_rd_ram;
            st_data0:      state <= cs_lost ? st_early_done :
                                    bus.valid_rise ? st_data1 : st_data0;
            // later words of a burst end normally on CS negation
            st_data0_b:    state <= cs_lost ? st_done :
                                    bus.valid_rise ? st_data1 : st_data0_b;
            st_data1:      state <= cs_lost ? st_early_done :
                                    bus.valid_rise ? st_data2 : st_data1;
            st_data2:      state <= cs_lost ? st_early_done :
                                    bus.valid_rise ? st_data3 : st_data2;
            // interval register takes no RAM write
            st_data3:      state <= cs_lost ? st_early_done :
                                    !bus.valid_rise ? st_data3 :
                                    is_intv ? st_data0_b : st_wr_ram;
            st_wr_ram:     state <= st_data0_b;
            st_rd_ram:     state <= cs_lost ? st_early_done : st_rd_master;
            // wait for the falling edge so master is not sampled mid-handover
            st_rd_master:  state <= cs_lost ? st_early_done :
                                    bus.valid_fall ? st_rd_master2 : st_rd_master;
            st_rd_master2: state <= cs_lost ? st_early_done :
                                    !bus.master ? st_rd_drive0 : st_rd_master2;
            st_rd_drive0:  state <= cs_lost ? st_early_done :
                                    bus.valid_fall ? st_rd_drive1 : st_rd_drive0;
            st_rd_drive1:  state <= cs_lost ? st_early_done :
                                    bus.valid_fall ? st_rd_drive2 : st_rd_drive1;
            st_rd_drive2:  state <= cs_lost ? st_early_done :
                                    bus.valid_fall ? st_rd_drive3 : st_rd_drive2;
            st_rd_drive3:  state <= cs_lost ? st_early_done :
                                    bus.valid_fall ? st_rd_done : st_rd_drive3;
            st_invalid_wr: state <= cs_lost ? st_done : st_invalid_wr;
            st_rd_done:    state <= cs_lost ? st_done : st_rd_done;
            st_early_done: state <= st_idle;
            st_done:       state <= st_idle;
            // only reset leaves the error state
            default:       state <= st_error;
         endcase
      end
   end

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= (state == st_rd_ram);
      end
   end

   // --------------------------------------------------
   // address and data assembly from the low byte up
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (state == st_addr0 && bus.valid_rise) begin
         uc_addr[uc_byte_w-1:0] <= bus.data;
      end else if (state == st_addr1 && bus.valid_rise) begin
         uc_addr[uc_addr_w-1:uc_byte_w] <= bus.data;
      end else if (state == st_wr_ram) begin
         // next word of a burst goes to the next address
         uc_addr <= uc_addr + uc_addr_w'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (bus.valid_rise) begin
         case (state)
            st_data0, st_data0_b: uc_data[7:0]   <= bus.data;
            st_data1:             uc_data[15:8]  <= bus.data;
            st_data2:             uc_data[23:16] <= bus.data;
            st_data3:             uc_data[31:24] <= bus.data;
            default:              uc_data        <= uc_data;
         endcase
      end
   end

   // fixed read values are loaded at decode time
   always_ff @(posedge clk) begin
      if (state == st_addr_dec && invalid_addr) begin
         rd_word <= bad_read_value;
      end else if (state == st_addr_dec && is_cool) begin
         rd_word <= coolcode_value;
      end else if (rd_pending) begin
         rd_word <= ram.rd_data;
      end
   end

   // --------------------------------------------------
   // RAM port and read byte drive
   // --------------------------------------------------
   assign ram.wr_en   = (state == st_wr_ram);
   assign ram.addr    = uc_addr[stat_addr_w-1:0];
   assign ram.wr_data = uc_data;
   // fourth byte of the interval register write
   assign ram.interval_done = (state == st_data3) && bus.cs && bus.valid_rise && is_intv;

   always_comb begin
      uc_data_out_val = 1'b1;
      case (state)
         st_rd_drive0: uc_data_out = rd_word[7:0];
         st_rd_drive1: uc_data_out = rd_word[15:8];
         st_rd_drive2: uc_data_out = rd_word[23:16];
         st_rd_drive3: uc_data_out = rd_word[31:24];
         default: begin
            uc_data_out_val = 1'b0;
            uc_data_out     = '0;
         end
      endcase
   end

endmodule

// ==== hdl/uc_sync_front.sv ====
/* uC bus input conditioning */
`timescale 1ns/1ns

module uc_sync_front import ucstats_pkg::*; (
   input  logic                 clk,
   input  logic                 uc_rst_n,
   input  logic                 uc_cs,
   input  logic                 uc_valid,
   input  logic                 uc_master,
   input  logic [uc_byte_w-1:0] uc_data_in,
   uc_line_if.front             bus
);

   // {cs, valid, master, data} through a two flop synchronizer
   logic [uc_byte_w+2:0] meta_q;
   logic [uc_byte_w+2:0] sync_q;
   logic                 valid_db;
   logic                 valid_q;

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= {uc_cs, uc_valid, uc_master, uc_data_in};
         sync_q <= meta_q;
      end
   end

   // --------------------------------------------------
   // debounce of the three control lines
   // --------------------------------------------------
   uc_debounce u_cs_db (
      .clk       (clk),
      .uc_rst_n  (uc_rst_n),
      .level_in  (sync_q[uc_byte_w+2]),
      .level_out (bus.cs)
   );

   uc_debounce u_valid_db (
      .clk       (clk),
      .uc_rst_n  (uc_rst_n),
      .level_in  (sync_q[uc_byte_w+1]),
      .level_out (valid_db)
   );

   uc_debounce u_master_db (
      .clk       (clk),
      .uc_rst_n  (uc_rst_n),
      .level_in  (sync_q[uc_byte_w]),
      .level_out (bus.master)
   );

   // valid edge detect
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= valid_db;
      end
   end

   // data is held well past the valid edge, no debounce needed
   assign bus.data       = sync_q[uc_byte_w-1:0];
   assign bus.valid_rise = valid_db & ~valid_q;
   assign bus.valid_fall = ~valid_db & valid_q;

endmodule

// ==== hdl/uc_debounce.sv ====
/* control line debounce */
`timescale 1ns/1ns

module uc_debounce (
   input  logic clk,
   input  logic uc_rst_n,
   input  logic level_in,
   output logic level_out
);

   // last sampled input level
   logic level_q;

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         level_q   <= 1'b0;
         level_out <= 1'b0;
      end else begin
         level_q <= level_in;
         // new level must be seen on two consecutive samples
         if (level_in == level_q) begin
            level_out <= level_in;
         end
      end
   end

endmodule

// ==== hdl/ucstats_ifs.sv ====
/* uC bridge internal interfaces */
`timescale 1ns/1ns

// conditioned uC bus, clk domain
interface uc_line_if import ucstats_pkg::*; ();
   logic                 cs;
   logic                 master;
   logic [uc_byte_w-1:0] data;
   // one cycle pulses on debounced valid edges
   logic                 valid_rise;
   logic                 valid_fall;

   modport front (
      output cs, master, data, valid_rise, valid_fall
   );

   modport fsm (
      input  cs, master, data, valid_rise, valid_fall
   );
endinterface

// uC side port of the stat RAM
interface stat_ram_if import ucstats_pkg::*; ();
   logic                   wr_en;
   logic [stat_addr_w-1:0] addr;
   logic [stat_data_w-1:0] wr_data;
   // registered, one cycle after addr
   logic [stat_data_w-1:0] rd_data;
   // pulse when a full interval has been written
   logic                   interval_done;

   modport fsm (
      output wr_en, addr, wr_data, interval_done,
      input  rd_data
   );

   modport ram (
      input  wr_en, addr, wr_data,
      output rd_data
   );

   // bank swap control only watches writes and interval end
   modport mon (
      input  wr_en, interval_done
   );
endinterface

// ==== hdl/ucstats_pkg.sv ====
/* uC stats bridge definitions */
package ucstats_pkg;

   // --------------------------------------------------
   // datapath widths
   // --------------------------------------------------
   localparam int uc_byte_w   = 8;
   localparam int stat_addr_w = 10;
   localparam int stat_data_w = 32;
   localparam int uc_addr_w   = 16;
   // words per stat bank
   localparam int stat_words  = 1 << stat_addr_w;

   // --------------------------------------------------
   // uC address fields
   // --------------------------------------------------
   // set for a write, clear for a read
   localparam int uc_wr_bit = 15;
   // space select, bits 11:10
   localparam int space_hi  = 11;
   localparam int space_lo  = 10;
   localparam logic [1:0] space_stat = 2'b00;
   localparam logic [1:0] space_fpga = 2'b01;

   // fpga register space offsets
   localparam logic [stat_addr_w-1:0] reg_interval_done = 10'd1;
   localparam logic [stat_addr_w-1:0] reg_coolcode      = 10'd2;

   localparam logic [stat_data_w-1:0] coolcode_value = 32'hc001_c0de;
   // returned for any read outside the decoded space
   localparam logic [stat_data_w-1:0] bad_read_value = 32'hdead_beef;

   // --------------------------------------------------
   // state encodings
   // --------------------------------------------------
   typedef enum logic [4:0] {
      st_idle       = 5'h00, st_addr0      = 5'h01, st_addr1      = 5'h02,
      st_addr_dec   = 5'h03, st_data0      = 5'h04, st_data0_b    = 5'h05,
      st_data1      = 5'h06, st_data2      = 5'h07, st_data3      = 5'h08,
      st_wr_ram     = 5'h09, st_rd_ram     = 5'h0a, st_rd_master  = 5'h0b,
      st_rd_master2 = 5'h0c, st_rd_drive0  = 5'h0d, st_rd_drive1  = 5'h0e,
      st_rd_drive2  = 5'h0f, st_rd_drive3  = 5'h10, st_early_done = 5'h11,
      st_rd_done    = 5'h12, st_done       = 5'h13, st_invalid_wr = 5'h14,
      st_error      = 5'h1f
   } uc_state_t;

   typedef enum logic [2:0] {
      bk_idle          = 3'h0,
      bk_writing       = 3'h1,
      bk_interval_done = 3'h2,
      bk_update        = 3'h3,
      bk_error         = 3'h7
   } bank_state_t;

endpackage
